//--- include/dcache_macros.svh
// data cache geometry
// 4-way set associative, 16 sets, 16-byte lines on a 32-bit address
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// ways per set
`define DC_WAYS        4
// number of sets
`define DC_SETS        16
// 32-bit words per line
`define DC_LINE_WORDS  4

// address split, tag + index + offset = 32
`define DC_OFFSET_W    4
`define DC_INDEX_W     4
`define DC_TAG_W       24

`endif

//--- hdl/dcache_pkg.sv
// data cache shared types
// address split, line and way vectors, cpu request, write-back beat, fsm states
`include "dcache_macros.svh"

package dcache_pkg;

    typedef struct packed {
        logic [`DC_TAG_W-1:0]    tag;
        logic [`DC_INDEX_W-1:0]  index;
        logic [`DC_OFFSET_W-1:0] offset;
    } dc_addr_t;

    typedef logic [`DC_LINE_WORDS-1:0][31:0] dc_line_t;

    typedef logic [`DC_WAYS-1:0] dc_way_t;  // one-hot

    typedef enum logic [1:0] {
        BYTE,
        HALF,
        WORD
    } load_size_e;

    typedef struct packed {
        logic       op;        // 0 load, 1 store
        dc_addr_t   addr;
        logic [3:0] wstrb;
        logic [31:0] wdata;
        load_size_e size;
        logic       sign_ext;
    } cpu_req_t;

    // one write-back beat, full line
    typedef struct packed {
        logic [31:0] addr;
        dc_line_t    data;
    } mem_wr_t;

    typedef enum logic [2:0] {
        LOOKUP,
        MISS_DIRTY,
        WRITEBACK,
        MISS_CLEAN,
        REFILL,
        REFILL_DONE
    } dc_state_e;

endpackage

//--- hdl/dcache_ctrl.sv
// data cache miss FSM
// sequences victim write-back and line refill, then returns to lookup
`timescale 1ns/100ps

module dcache_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  lookup_valid,
    input  logic                  hit,
    input  logic                  victim_dirty,
    input  logic                  mem_rd_rdy,
    input  logic                  mem_ret_valid,
    input  logic                  mem_wr_rdy,
    input  logic                  mem_wr_done,
    output dcache_pkg::dc_state_e state
);
    import dcache_pkg::*;

    dc_state_e state_next;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= LOOKUP;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            LOOKUP: begin
                // miss picks the path by the victim's dirty bit
                if (lookup_valid && !hit) begin
                    state_next = victim_dirty ? MISS_DIRTY : MISS_CLEAN;
                end
            end
            MISS_DIRTY: begin
                if (mem_wr_rdy) begin
                    state_next = WRITEBACK;
                end
            end
            WRITEBACK: begin
                if (mem_wr_done) begin  // victim safely in memory
                    state_next = MISS_CLEAN;
                end
            end
            MISS_CLEAN: begin
                if (mem_rd_rdy) begin
                    state_next = REFILL;
                end
            end
            REFILL: begin
                if (mem_ret_valid) begin  // line written this edge
                    state_next = REFILL_DONE;
                end
            end
            REFILL_DONE: begin
                state_next = LOOKUP;  // held request now hits
            end
            default: begin
                state_next = LOOKUP;
            end
        endcase
    end

    // memory must not return a line the cache never asked for
    a_ret_in_refill: assert property (
        @(posedge clk) disable iff (!rst_n)
        mem_ret_valid |-> state == REFILL
    ) else $error("dcache_ctrl: line returned outside REFILL");

endmodule

//--- hdl/dcache_tag_array.sv
// valid, tag and dirty storage for all sets and ways
// parallel tag compare, victim status, refill and store-hit updates
`timescale 1ns/100ps
`include "dcache_macros.svh"

module dcache_tag_array (
    input  logic                 clk,
    input  logic                 rst_n,
    input  dcache_pkg::dc_addr_t addr,
    input  logic                 refill_we,
    input  logic                 store_hit,
    input  dcache_pkg::dc_way_t  victim,
    output dcache_pkg::dc_way_t  hit_way,
    output logic                 victim_dirty,
    output logic [`DC_TAG_W-1:0] victim_tag
);

    logic [`DC_WAYS-1:0]  valid_q [`DC_SETS];
    logic [`DC_WAYS-1:0]  dirty_q [`DC_SETS];
    logic [`DC_TAG_W-1:0] tag_q   [`DC_SETS][`DC_WAYS];

    // asynchronous read of the addressed set
    always_comb begin
        hit_way      = '0;
        victim_dirty = 1'b0;
        victim_tag   = '0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            hit_way[w] = valid_q[addr.index][w] && (tag_q[addr.index][w] == addr.tag);
            if (victim[w]) begin
                // an invalid way never needs a write-back
                victim_dirty = valid_q[addr.index][w] && dirty_q[addr.index][w];
                victim_tag   = tag_q[addr.index][w];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < `DC_SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else if (refill_we) begin
            valid_q[addr.index] <= valid_q[addr.index] | victim;
            dirty_q[addr.index] <= dirty_q[addr.index] & ~victim;  // fresh line is clean
        end else if (store_hit) begin
            dirty_q[addr.index] <= dirty_q[addr.index] | hit_way;
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (refill_we && victim[w]) begin
                tag_q[addr.index][w] <= addr.tag;
            end
        end
    end

    // a tag may live in only one way of a set
    a_hit_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        |hit_way |-> $onehot(hit_way)
    ) else $error("dcache_tag_array: tag present in several ways");

endmodule

//--- hdl/dcache_data_array.sv
// line storage for all sets and ways
// hit word select, byte-strobed store merge, victim line read, refill write
`timescale 1ns/100ps
`include "dcache_macros.svh"

module dcache_data_array (
    input  logic                 clk,
    input  logic                 rst_n,
    input  dcache_pkg::dc_addr_t addr,
    input  dcache_pkg::dc_way_t  hit_way,
    input  dcache_pkg::dc_way_t  victim,
    input  logic                 refill_we,
    input  dcache_pkg::dc_line_t refill_line,
    input  logic                 store_we,
    input  logic [3:0]           wstrb,
    input  logic [31:0]          wdata,
    output logic [31:0]          word,
    output dcache_pkg::dc_line_t victim_line
);
    import dcache_pkg::*;

    dc_line_t mem_q [`DC_SETS][`DC_WAYS];
    dc_line_t hit_line;
    logic [$clog2(`DC_LINE_WORDS)-1:0] word_sel;
    logic [31:0] merged;

    assign word_sel = addr.offset[`DC_OFFSET_W-1:2];

    // one-hot way muxes
    always_comb begin
        hit_line    = '0;
        victim_line = '0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (hit_way[w]) begin
                hit_line = mem_q[addr.index][w];
            end
            if (victim[w]) begin
                victim_line = mem_q[addr.index][w];
            end
        end
    end

    assign word = hit_line[word_sel];

    always_comb begin
        for (int b = 0; b < 4; b++) begin
            merged[b*8 +: 8] = wstrb[b] ? wdata[b*8 +: 8] : word[b*8 +: 8];
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (refill_we && victim[w]) begin
                mem_q[addr.index][w] <= refill_line;
            end else if (store_we && hit_way[w]) begin
                mem_q[addr.index][w][word_sel] <= merged;  // only the addressed word
            end
        end
    end

    // refill happens in REFILL, store hits only in LOOKUP
    a_no_write_clash: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(refill_we && store_we)
    ) else $error("dcache_data_array: refill and store in one cycle");

endmodule

//--- hdl/dcache_plru.sv
// tree pseudo-LRU, three bits per set
// bit0 picks the half, bit1 ways 0/1, bit2 ways 2/3, 0 means lower
`timescale 1ns/100ps
`include "dcache_macros.svh"

module dcache_plru (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`DC_INDEX_W-1:0]  index,
    input  dcache_pkg::dc_way_t     access_way,
    input  logic                    update,
    output dcache_pkg::dc_way_t     victim
);

    logic [2:0] tree_q [`DC_SETS];
    logic [2:0] cur;

    assign cur = tree_q[index];

    // follow the tree bits down to a leaf
    always_comb begin
        victim = '0;
        if (!cur[0]) begin
            victim[cur[1]] = 1'b1;
        end else begin
            victim[{1'b1, cur[2]}] = 1'b1;
        end
    end

    // point the path bits away from the way just used
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < `DC_SETS; s++) begin
                tree_q[s] <= '0;
            end
        end else if (update) begin
            case (access_way)
                4'b0001: tree_q[index] <= {cur[2], 1'b1, 1'b1};
                4'b0010: tree_q[index] <= {cur[2], 1'b0, 1'b1};
                4'b0100: tree_q[index] <= {1'b1, cur[1], 1'b0};
                4'b1000: tree_q[index] <= {1'b0, cur[1], 1'b0};
                default: tree_q[index] <= cur;
            endcase
        end
    end

    // a hit names exactly one way to move away from
    a_access_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        update |-> $onehot(access_way)
    ) else $error("dcache_plru: update without a one-hot way");

endmodule

//--- hdl/dcache_load_align.sv
// load data alignment
// picks the addressed byte or halfword out of the word, sign or zero extends
`timescale 1ns/100ps

module dcache_load_align (
    input  logic                   [31:0] word,
    input  logic                   [1:0]  offset,
    input  dcache_pkg::load_size_e        size,
    input  logic                          sign_ext,
    output logic                   [31:0] rdata
);
    import dcache_pkg::*;

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    assign byte_sel = word[{offset, 3'b000} +: 8];
    assign half_sel = offset[1] ? word[31:16] : word[15:0];  // offset[0] ignored for halves

    always_comb begin
        case (size)
            BYTE: begin
                rdata = {{24{sign_ext & byte_sel[7]}}, byte_sel};
            end
            HALF: begin
                rdata = {{16{sign_ext & half_sel[15]}}, half_sel};
            end
            default: begin
                rdata = word;
            end
        endcase
    end

endmodule

//--- hdl/dcache_top.sv
// 4-way write-back, write-allocate data cache
// request register, hit/busy/response logic and the line-wide memory ports
`timescale 1ns/100ps
`include "dcache_macros.svh"

module dcache_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 req_valid,
    input  dcache_pkg::cpu_req_t req,
    output logic                 busy,
    output logic                 resp_valid,
    output logic [31:0]          rdata,
    output logic                 mem_rd_req,
    output logic [31:0]          mem_rd_addr,
    input  logic                 mem_rd_rdy,
    input  logic                 mem_ret_valid,
    input  dcache_pkg::dc_line_t mem_ret_data,
    output logic                 mem_wr_req,
    output dcache_pkg::mem_wr_t  mem_wr,
    input  logic                 mem_wr_rdy,
    input  logic                 mem_wr_done
);
    import dcache_pkg::*;

    cpu_req_t             req_q;
    logic                 req_vld_q;
    logic                 accept;
    dc_state_e            state;
    dc_way_t              hit_way;
    dc_way_t              victim;
    logic                 hit;
    logic                 victim_dirty;
    logic [`DC_TAG_W-1:0] victim_tag;
    dc_line_t             victim_line;
    logic                 refill_we;
    logic                 store_hit;
    logic [31:0]          word;
    logic [31:0]          load_data;

    assign accept     = req_valid && !busy;
    assign hit        = |hit_way;
    assign resp_valid = req_vld_q && (state == LOOKUP) && hit;
    assign busy       = (state != LOOKUP) || (req_vld_q && !hit);  // miss raises busy at once
    assign store_hit  = resp_valid && req_q.op;
    assign refill_we  = (state == REFILL) && mem_ret_valid;
    assign rdata      = (resp_valid && !req_q.op) ? load_data : '0;

    // memory side, whole line per beat
    assign mem_rd_req  = (state == MISS_CLEAN);
    assign mem_rd_addr = {req_q.addr.tag, req_q.addr.index, {`DC_OFFSET_W{1'b0}}};
    assign mem_wr_req  = (state == MISS_DIRTY);
    assign mem_wr.addr = {victim_tag, req_q.addr.index, {`DC_OFFSET_W{1'b0}}};
    assign mem_wr.data = victim_line;

    // request held until its response, a new one may load in the hit cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_vld_q <= 1'b0;
            req_q     <= '0;
        end else if (accept) begin
            req_vld_q <= 1'b1;
            req_q     <= req;
        end else if (resp_valid) begin
            req_vld_q <= 1'b0;
        end
    end

    dcache_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .lookup_valid (req_vld_q),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .mem_rd_rdy   (mem_rd_rdy),
        .mem_ret_valid(mem_ret_valid),
        .mem_wr_rdy   (mem_wr_rdy),
        .mem_wr_done  (mem_wr_done),
        .state        (state)
    );

    dcache_tag_array u_tag (
        .clk         (clk),
        .rst_n       (rst_n),
        .addr        (req_q.addr),
        .refill_we   (refill_we),
        .store_hit   (store_hit),
        .victim      (victim),
        .hit_way     (hit_way),
        .victim_dirty(victim_dirty),
        .victim_tag  (victim_tag)
    );

    dcache_data_array u_data (
        .clk        (clk),
        .rst_n      (rst_n),
        .addr       (req_q.addr),
        .hit_way    (hit_way),
        .victim     (victim),
        .refill_we  (refill_we),
        .refill_line(mem_ret_data),
        .store_we   (store_hit),
        .wstrb      (req_q.wstrb),
        .wdata      (req_q.wdata),
        .word       (word),
        .victim_line(victim_line)
    );

    // only hits touch the LRU, so the victim holds still through a miss
    dcache_plru u_plru (
        .clk       (clk),
        .rst_n     (rst_n),
        .index     (req_q.addr.index),
        .access_way(hit_way),
        .update    (resp_valid),
        .victim    (victim)
    );

    dcache_load_align u_align (
        .word    (word),
        .offset  (req_q.addr.offset[1:0]),
        .size    (req_q.size),
        .sign_ext(req_q.sign_ext),
        .rdata   (load_data)
    );

endmodule

//--- dv/dcache_ref_model.sv
// reference model for the data cache
// line-wide main memory with random wait states, plus shadow tags, dirty and PLRU
`timescale 1ns/100ps

module dcache_ref_model (
    input  logic                 clk,
    input  logic [1:0]           rd_delay,
    input  logic [1:0]           wr_delay,
    input  logic                 mem_rd_req,
    input  logic [31:0]          mem_rd_addr,
    output logic                 mem_rd_rdy,
    output logic                 mem_ret_valid,
    output dcache_pkg::dc_line_t mem_ret_data,
    input  logic                 mem_wr_req,
    input  dcache_pkg::mem_wr_t  mem_wr,
    output logic                 mem_wr_rdy,
    output logic                 mem_wr_done,
    output int                   wr_count,
    output int                   rd_count,
    output dcache_pkg::mem_wr_t  last_wr,
    output logic [31:0]          last_rd_addr
);
    import dcache_pkg::*;

    logic [31:0] backing [256];  // what memory holds
    logic [31:0] golden  [256];  // what the cpu should see
    logic [23:0] tags    [16][4];
    logic [3:0]  valid   [16];
    logic [3:0]  dirty   [16];
    logic [2:0]  tree    [16];

    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return (a * 32'h9e3779b1) ^ {a[15:0], a[31:16]} ^ 32'h3c6ef372;
    endfunction

    // 64 lines as 8 sets by 8 tags, 4 words each
    function automatic int word_slot(input logic [31:0] a);
        return {a[10:8], a[6:4], a[3:2]};
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic serve_write();
        mem_wr_t beat;
        beat = mem_wr;  // stable for the whole of MISS_DIRTY
        wait_cycles(wr_delay);
        mem_wr_rdy = 1'b1;
        wait_cycles(1);
        mem_wr_rdy = 1'b0;
        wait_cycles(wr_delay);
        mem_wr_done = 1'b1;
        wait_cycles(1);
        mem_wr_done = 1'b0;
        for (int k = 0; k < 4; k++) begin
            backing[word_slot(beat.addr) + k] = beat.data[k];
        end
        last_wr = beat;
        wr_count++;
    endtask

    task automatic serve_read();
        logic [31:0] addr;
        addr = mem_rd_addr;
        wait_cycles(rd_delay);
        mem_rd_rdy = 1'b1;
        wait_cycles(1);
        mem_rd_rdy = 1'b0;
        wait_cycles(rd_delay);
        for (int k = 0; k < 4; k++) begin
            mem_ret_data[k] = backing[word_slot(addr) + k];
        end
        mem_ret_valid = 1'b1;
        wait_cycles(1);
        mem_ret_valid = 1'b0;
        last_rd_addr = addr;
        rd_count++;
    endtask

    initial begin
        mem_rd_rdy    = 1'b0;
        mem_ret_valid = 1'b0;
        mem_wr_rdy    = 1'b0;
        mem_wr_done   = 1'b0;
        mem_ret_data  = '0;
        wr_count      = 0;
        rd_count      = 0;
        last_wr       = '0;
        last_rd_addr  = '0;
        for (int s = 0; s < 256; s++) begin
            backing[s] = fill_word({21'b0, s[7:5], 1'b0, s[4:2], s[1:0], 2'b00});
            golden[s]  = backing[s];
        end
        for (int s = 0; s < 16; s++) begin
            valid[s] = '0;
            dirty[s] = '0;
            tree[s]  = '0;
            for (int w = 0; w < 4; w++) begin
                tags[s][w] = '0;
            end
        end
        forever begin
            @(posedge clk);
            #2;
            if (mem_wr_req) begin
                serve_write();
            end else if (mem_rd_req) begin
                serve_read();
            end
        end
    end

    // shadow cache, updated once per request in issue order
    task automatic predict(input cpu_req_t r, output logic hit, output logic wb,
                           output mem_wr_t wr_exp, output logic [31:0] rd_addr_exp,
                           output logic [31:0] rdata_exp);
        int          idx;
        int          way;
        int          slot;
        logic [31:0] w;
        logic [7:0]  b;
        logic [15:0] h;
        idx         = r.addr.index;
        way         = -1;
        wb          = 1'b0;
        wr_exp      = '0;
        rd_addr_exp = {r.addr.tag, r.addr.index, 4'h0};
        for (int k = 0; k < 4; k++) begin
            if (valid[idx][k] && tags[idx][k] == r.addr.tag) begin
                way = k;
            end
        end
        hit = (way >= 0);
        if (!hit) begin
            way = tree[idx][0] ? 2 + tree[idx][2] : tree[idx][1];
            wb  = valid[idx][way] && dirty[idx][way];
            wr_exp.addr = {tags[idx][way], r.addr.index, 4'h0};
            for (int k = 0; k < 4; k++) begin
                wr_exp.data[k] = golden[word_slot(wr_exp.addr) + k];
            end
            tags[idx][way]  = r.addr.tag;
            valid[idx][way] = 1'b1;
            dirty[idx][way] = 1'b0;
        end
        if (way < 2) begin  // path bits point away from the used way
            tree[idx][0] = 1'b1;
            tree[idx][1] = (way == 0);
        end else begin
            tree[idx][0] = 1'b0;
            tree[idx][2] = (way == 2);
        end
        slot = word_slot(r.addr);
        w    = golden[slot];
        if (r.op) begin
            for (int k = 0; k < 4; k++) begin
                if (r.wstrb[k]) w[k*8 +: 8] = r.wdata[k*8 +: 8];
            end
            golden[slot]    = w;
            dirty[idx][way] = 1'b1;
            rdata_exp       = '0;
        end else begin
            b = w[r.addr.offset[1:0]*8 +: 8];
            h = r.addr.offset[1] ? w[31:16] : w[15:0];
            case (r.size)
                BYTE:    rdata_exp = {{24{r.sign_ext & b[7]}}, b};
                HALF:    rdata_exp = {{16{r.sign_ext & h[15]}}, h};
                default: rdata_exp = w;
            endcase
        end
    endtask

endmodule

//--- dv/dcache_tb.sv
// testbench for the data cache
// LFSR driven loads and stores, checked against the reference model
`timescale 1ns/100ps

module dcache_tb;
    import dcache_pkg::*;

    localparam int N_DIRECTED     = 16;
    localparam int N_RANDOM       = 400;
    localparam int MAX_REQUESTS   = N_DIRECTED + 2 * N_RANDOM;  // each store adds a reload
    localparam int CYCLES_PER_REQ = 200;

    logic        clk;
    logic        rst_n;
    logic        req_valid;
    cpu_req_t    req;
    logic        busy;
    logic        resp_valid;
    logic [31:0] rdata;
    logic        mem_rd_req;
    logic [31:0] mem_rd_addr;
    logic        mem_rd_rdy;
    logic        mem_ret_valid;
    dc_line_t    mem_ret_data;
    logic        mem_wr_req;
    mem_wr_t     mem_wr;
    logic        mem_wr_rdy;
    logic        mem_wr_done;
    logic [1:0]  rd_delay;
    logic [1:0]  wr_delay;
    int          wr_count;
    int          rd_count;
    mem_wr_t     last_wr;
    logic [31:0] last_rd_addr;
    logic [31:0] lfsr_state;
    int          errors;

    dcache_top u_dut (
        .clk(clk), .rst_n(rst_n), .req_valid(req_valid), .req(req), .busy(busy),
        .resp_valid(resp_valid), .rdata(rdata), .mem_rd_req(mem_rd_req),
        .mem_rd_addr(mem_rd_addr), .mem_rd_rdy(mem_rd_rdy), .mem_ret_valid(mem_ret_valid),
        .mem_ret_data(mem_ret_data), .mem_wr_req(mem_wr_req), .mem_wr(mem_wr),
        .mem_wr_rdy(mem_wr_rdy), .mem_wr_done(mem_wr_done)
    );

    dcache_ref_model u_model (
        .clk(clk), .rd_delay(rd_delay), .wr_delay(wr_delay), .mem_rd_req(mem_rd_req),
        .mem_rd_addr(mem_rd_addr), .mem_rd_rdy(mem_rd_rdy), .mem_ret_valid(mem_ret_valid),
        .mem_ret_data(mem_ret_data), .mem_wr_req(mem_wr_req), .mem_wr(mem_wr),
        .mem_wr_rdy(mem_wr_rdy), .mem_wr_done(mem_wr_done), .wr_count(wr_count),
        .rd_count(rd_count), .last_wr(last_wr), .last_rd_addr(last_rd_addr)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run();
        errors++;
        $display("FAIL: see errors above");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_wr(input mem_wr_t got, input mem_wr_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: write-back 0x%08h/%h, expected 0x%08h/%h",
                     $time, got.addr, got.data, exp.addr, exp.data);
            abort_run();
        end
    endtask

    task automatic check_addr(input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: refill address 0x%08h, expected 0x%08h", $time, got, exp);
            abort_run();
        end
    endtask

    // galois form, taps for x^32+x^22+x^2+x+1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
    endtask

    // line 0..63 maps to sets 0..7, tags 0..7
    function automatic cpu_req_t build_req(input logic [5:0] line, input logic [3:0] off,
                                           input logic op);
        cpu_req_t r;
        r             = '0;
        r.op          = op;
        r.addr.tag    = {21'b0, line[5:3]};
        r.addr.index  = {1'b0, line[2:0]};
        r.addr.offset = off;
        r.wstrb       = 4'hf;
        r.wdata       = {26'h2b5e0c1, line};
        r.size        = WORD;
        return r;
    endfunction

    task automatic run_request(input cpu_req_t r);
        logic        exp_hit;
        logic        exp_wb;
        mem_wr_t     exp_wr;
        logic [31:0] exp_rd_addr;
        logic [31:0] exp_rdata;
        int          wr_before;
        int          rd_before;
        int          waited;
        u_model.predict(r, exp_hit, exp_wb, exp_wr, exp_rd_addr, exp_rdata);
        wr_before = wr_count;
        rd_before = rd_count;
        waited    = 0;
        req       = r;
        req_valid = 1'b1;
        @(posedge clk);
        #2;
        req_valid = 1'b0;
        while (!resp_valid) begin
            check_word({31'b0, busy}, 32'd1, "busy while missing");
            @(posedge clk);
            #2;
            waited++;
        end
        check_word({31'b0, busy}, 32'd0, "busy with the response");
        if (exp_hit && waited != 0) begin
            $display("Hit at %0t answered %0d cycles late", $time, waited);
            abort_run();
        end
        check_word(rdata, exp_rdata, "read data");
        if ((wr_count - wr_before) != (exp_wb ? 1 : 0)) begin
            $display("Wrong number of write-backs for the request ending at %0t", $time);
            abort_run();
        end
        if ((rd_count - rd_before) != (exp_hit ? 0 : 1)) begin
            $display("Wrong number of refills for the request ending at %0t", $time);
            abort_run();
        end
        if (exp_wb) check_wr(last_wr, exp_wr);
        if (!exp_hit) check_addr(last_rd_addr, exp_rd_addr);
    endtask

    task automatic random_request();
        logic [31:0] v [9];
        cpu_req_t    r;
        rand_bits(6, v[0]);   // line
        rand_bits(4, v[1]);   // byte offset
        rand_bits(1, v[2]);
        rand_bits(4, v[3]);   // store strobe
        rand_bits(32, v[4]);
        rand_bits(2, v[5]);
        rand_bits(1, v[6]);
        rand_bits(2, v[7]);   // memory wait states
        rand_bits(2, v[8]);
        rd_delay   = v[7][1:0];
        wr_delay   = v[8][1:0];
        r          = build_req(v[0][5:0], v[1][3:0], v[2][0]);
        r.wstrb    = v[3][3:0];
        r.wdata    = v[4];
        r.size     = (v[5][1:0] == 2'd3) ? WORD : load_size_e'(v[5][1:0]);
        r.sign_ext = v[6][0];
        run_request(r);
        if (r.op) begin  // read back the merged word
            r.op   = 1'b0;
            r.size = WORD;
            run_request(r);
        end
    endtask

    initial begin
        #(MAX_REQUESTS * CYCLES_PER_REQ * 20);
        $display("Watchdog expired at %0t, the cache stopped answering", $time);
        abort_run();
    end

    initial begin
        errors     = 0;
        lfsr_state = 32'h7184ff21;
        rst_n      = 1'b0;
        req_valid  = 1'b0;
        req        = '0;
        rd_delay   = 2'd0;
        wr_delay   = 2'd0;
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(posedge clk);
        #2;
        check_word({28'b0, busy, resp_valid, mem_rd_req, mem_wr_req}, '0, "idle levels");
        // fill set 5 past its four ways, then dirty every tag in turn
        for (int t = 0; t < 8; t++) begin
            run_request(build_req({t[2:0], 3'd5}, 4'h0, 1'b0));
        end
        for (int t = 0; t < 8; t++) begin
            run_request(build_req({t[2:0], 3'd5}, 4'h4, 1'b1));
        end
        for (int n = 0; n < N_RANDOM; n++) begin
            random_request();
        end
        if (errors == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            abort_run();
        end
    end

endmodule

//--- sources.f
+incdir+include
hdl/dcache_pkg.sv
hdl/dcache_ctrl.sv
hdl/dcache_tag_array.sv
hdl/dcache_data_array.sv
hdl/dcache_plru.sv
hdl/dcache_load_align.sv
hdl/dcache_top.sv
dv/dcache_ref_model.sv
dv/dcache_tb.sv
